// File: common/periph_pkg.sv
// Peripheral subsystem package
// Bus widths, interrupt controller sizing and the register map shared
// by the decoder, the timer block and the PLIC

package periph_pkg;

    // Register bus
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // ------------------------------------------------------------------------
    // Interrupt controller sizing
    // ------------------------------------------------------------------------
    localparam int NumSources  = 4;  // IDs 1..4, ID 0 is no interrupt
    localparam int NumTargets  = 2;
    localparam int MaxPriority = 7;
    localparam int TimerCnt    = 2;

    typedef logic [$clog2(NumSources+1)-1:0]  src_id_t;
    typedef logic [$clog2(MaxPriority+1)-1:0] prio_t;
    typedef logic [NumSources-1:0]            src_vec_t;  // bit 0 is source 1

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------
    localparam logic [3:0] RegionPlic  = 4'h0;  // addr[15:12]
    localparam logic [3:0] RegionTimer = 4'h1;

    localparam logic [11:0] PlicPrioBase   = 12'h000;  // + 4 * source
    localparam logic [11:0] PlicPendingOff = 12'h080;
    localparam logic [11:0] PlicEnableBase = 12'h100;  // + 4 * target
    localparam logic [11:0] PlicTargetBase = 12'h200;  // + 8 * target, claim at +4

    // Timer n at n * stride: counter, compare, control, status
    localparam logic [11:0] TimerStride = 12'h010;

endpackage

// File: verilog/reg_decode.sv
// Register bus decoder
// Picks the block from address bits 15:12, muxes its answer and
// returns a registered response one cycle after the request

`timescale 1ns/1ps

module reg_decode import periph_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        req_valid_i,
    input  logic        req_write_i,
    input  reg_addr_t   req_addr_i,
    input  reg_data_t   req_wdata_i,
    output logic        plic_sel_o,
    output logic        timer_sel_o,
    output logic [11:0] offset_o,
    output logic        write_o,
    output reg_data_t   wdata_o,
    input  reg_data_t   plic_rdata_i,
    input  logic        plic_err_i,
    input  reg_data_t   timer_rdata_i,
    input  logic        timer_err_i,
    output logic        rsp_valid_o,
    output reg_data_t   rsp_rdata_o,
    output logic        rsp_err_o
);

    logic [3:0] region;
    reg_data_t  blk_rdata;
    logic       blk_err;

    assign region      = req_addr_i[15:12];
    assign plic_sel_o  = req_valid_i && (region == RegionPlic);
    assign timer_sel_o = req_valid_i && (region == RegionTimer);
    assign offset_o    = req_addr_i[11:0];
    assign write_o     = req_write_i;
    assign wdata_o     = req_wdata_i;

    always_comb begin
        case (region)
            RegionPlic: begin
                blk_rdata = plic_rdata_i;
                blk_err   = plic_err_i;
            end
            RegionTimer: begin
                blk_rdata = timer_rdata_i;
                blk_err   = timer_err_i;
            end
            default: begin       // Nothing lives here
                blk_rdata = '0;
                blk_err   = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            rsp_err_o   <= 1'b0;
            rsp_rdata_o <= '0;
        end else begin
            rsp_valid_o <= req_valid_i;
            rsp_err_o   <= req_valid_i && blk_err;
            if (req_valid_i) begin
                rsp_rdata_o <= blk_err ? '0 : blk_rdata;
            end
        end
    end

    // One response per request, always in the next cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o == $past(req_valid_i));

endmodule

// File: timer/timer_unit.sv
// Timer block
// Free-running counters with compare match, enable and a sticky
// interrupt flag per timer; the counter wraps to 0 on a match

`timescale 1ns/1ps

module timer_unit import periph_pkg::*; #(
    parameter int TimerCnt = periph_pkg::TimerCnt
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                sel_i,
    input  logic [11:0]         offset_i,
    input  logic                write_i,
    input  reg_data_t           wdata_i,
    output reg_data_t           rdata_o,
    output logic                err_o,
    output logic [TimerCnt-1:0] irq_o
);

    reg_data_t           cnt_q [TimerCnt];
    reg_data_t           cmp_q [TimerCnt];
    logic [TimerCnt-1:0] en_q;
    logic [TimerCnt-1:0] flag_q;

    logic [TimerCnt-1:0] cnt_we, cmp_we, ctrl_we, clr;
    logic [TimerCnt-1:0] match;
    logic                hit;

    // ------------------------------------------------------------------------
    // Register access
    // ------------------------------------------------------------------------
    always_comb begin
        logic [11:0] base;
        rdata_o = '0;
        hit     = 1'b0;
        cnt_we  = '0;
        cmp_we  = '0;
        ctrl_we = '0;
        clr     = '0;
        for (int i = 0; i < TimerCnt; i++) begin
            base = TimerStride * 12'(i);
            if (offset_i == base) begin
                hit       = 1'b1;
                rdata_o   = cnt_q[i];
                cnt_we[i] = sel_i && write_i;
            end
            if (offset_i == base + 12'h4) begin
                hit       = 1'b1;
                rdata_o   = cmp_q[i];
                cmp_we[i] = sel_i && write_i;
            end
            if (offset_i == base + 12'h8) begin
                hit        = 1'b1;
                rdata_o    = reg_data_t'(en_q[i]);
                ctrl_we[i] = sel_i && write_i;
            end
            if (offset_i == base + 12'hC) begin
                hit     = 1'b1;
                rdata_o = reg_data_t'(flag_q[i]);
                clr[i]  = sel_i && write_i && wdata_i[0];  // Write 1 to clear
            end
        end
    end

    assign err_o = sel_i && !hit;

    always_comb begin
        for (int i = 0; i < TimerCnt; i++) begin
            match[i] = en_q[i] && (cnt_q[i] == cmp_q[i]);
        end
    end

    // ------------------------------------------------------------------------
    // Counters and flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TimerCnt; i++) begin
                cnt_q[i] <= '0;
                cmp_q[i] <= '0;
            end
            en_q   <= '0;
            flag_q <= '0;
        end else begin
            for (int i = 0; i < TimerCnt; i++) begin
                if (cnt_we[i]) cnt_q[i] <= wdata_i;
                else if (match[i]) cnt_q[i] <= '0;
                else if (en_q[i]) cnt_q[i] <= cnt_q[i] + 1'b1;
                if (cmp_we[i]) cmp_q[i] <= wdata_i;
                if (ctrl_we[i]) en_q[i] <= wdata_i[0];
                if (match[i]) flag_q[i] <= 1'b1;  // Match wins over clear
                else if (clr[i]) flag_q[i] <= 1'b0;
            end
        end
    end

    assign irq_o = flag_q;

    for (genvar i = 0; i < TimerCnt; i++) begin : gen_flag_chk
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $rose(flag_q[i]) |-> $past(en_q[i]));
    end

endmodule

// File: plic/plic_gateway.sv
// PLIC gateways
// One per source; a high level on an idle source becomes pending,
// a claim moves it to in service and a complete frees it again

`timescale 1ns/1ps

module plic_gateway import periph_pkg::*; #(
    parameter int NumSources = periph_pkg::NumSources,
    parameter int NumTargets = periph_pkg::NumTargets
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  src_vec_t                 src_i,
    input  logic    [NumTargets-1:0] claim_i,
    input  src_id_t [NumTargets-1:0] claim_id_i,
    input  logic    [NumTargets-1:0] complete_i,
    input  src_id_t [NumTargets-1:0] complete_id_i,
    output src_vec_t                 pending_o
);

    src_vec_t pending_q, active_q;
    src_vec_t claim_hit, comp_hit;

    // Match the claim and complete IDs of all targets against each source
    always_comb begin
        claim_hit = '0;
        comp_hit  = '0;
        for (int i = 0; i < NumSources; i++) begin
            for (int t = 0; t < NumTargets; t++) begin
                if (claim_i[t] && claim_id_i[t] == src_id_t'(i + 1)) claim_hit[i] = 1'b1;
                if (complete_i[t] && complete_id_i[t] == src_id_t'(i + 1)) comp_hit[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
            active_q  <= '0;
        end else begin
            pending_q <= (pending_q & ~claim_hit) | (src_i & ~pending_q & ~active_q);
            active_q  <= (active_q & ~comp_hit) | (pending_q & claim_hit);
        end
    end

    assign pending_o = pending_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pending_q & active_q) == '0);

endmodule

// File: plic/plic_regs.sv
// PLIC configuration registers
// Source priorities, per-target enables and thresholds, the pending
// vector and the claim/complete registers

`timescale 1ns/1ps

module plic_regs import periph_pkg::*; #(
    parameter int NumSources = periph_pkg::NumSources,
    parameter int NumTargets = periph_pkg::NumTargets
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      sel_i,
    input  logic [11:0]               offset_i,
    input  logic                      write_i,
    input  reg_data_t                 wdata_i,
    output reg_data_t                 rdata_o,
    output logic                      err_o,
    input  src_vec_t                  pending_i,
    input  src_id_t  [NumTargets-1:0] max_id_i,
    output prio_t    [NumSources-1:0] prio_o,
    output src_vec_t [NumTargets-1:0] enable_o,
    output prio_t    [NumTargets-1:0] threshold_o,
    output logic     [NumTargets-1:0] claim_o,
    output src_id_t  [NumTargets-1:0] claim_id_o,
    output logic     [NumTargets-1:0] complete_o,
    output src_id_t  [NumTargets-1:0] complete_id_o
);

    prio_t    [NumSources-1:0] prio_q;
    src_vec_t [NumTargets-1:0] enable_q;
    prio_t    [NumTargets-1:0] threshold_q;

    logic [NumSources-1:0] prio_we;
    logic [NumTargets-1:0] en_we, thr_we;
    logic                  hit;

    // ------------------------------------------------------------------------
    // Address decode and read mux
    // ------------------------------------------------------------------------
    always_comb begin
        rdata_o    = '0;
        hit        = 1'b0;
        prio_we    = '0;
        en_we      = '0;
        thr_we     = '0;
        claim_o    = '0;
        complete_o = '0;
        if (offset_i == PlicPendingOff) begin  // Read only
            hit     = 1'b1;
            rdata_o = reg_data_t'(pending_i);
        end
        for (int i = 0; i < NumSources; i++) begin
            if (offset_i == PlicPrioBase + 12'(4 * (i + 1))) begin
                hit        = 1'b1;
                rdata_o    = reg_data_t'(prio_q[i]);
                prio_we[i] = sel_i && write_i;
            end
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (offset_i == PlicEnableBase + 12'(4 * t)) begin
                hit      = 1'b1;
                rdata_o  = reg_data_t'(enable_q[t]);
                en_we[t] = sel_i && write_i;
            end
            if (offset_i == PlicTargetBase + 12'(8 * t)) begin
                hit       = 1'b1;
                rdata_o   = reg_data_t'(threshold_q[t]);
                thr_we[t] = sel_i && write_i;
            end
            // Read claims, write completes
            if (offset_i == PlicTargetBase + 12'(8 * t + 4)) begin
                hit           = 1'b1;
                rdata_o       = reg_data_t'(max_id_i[t]);
                claim_o[t]    = sel_i && !write_i && (max_id_i[t] != '0);
                complete_o[t] = sel_i && write_i;
            end
        end
    end

    assign err_o         = sel_i && !hit;
    assign claim_id_o    = max_id_i;
    assign complete_id_o = {NumTargets{wdata_i[$bits(src_id_t)-1:0]}};

    // ------------------------------------------------------------------------
    // Configuration storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q      <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
        end else begin
            for (int i = 0; i < NumSources; i++) begin
                if (prio_we[i]) prio_q[i] <= wdata_i[$bits(prio_t)-1:0];
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (en_we[t]) enable_q[t] <= wdata_i[NumSources-1:0];
                if (thr_we[t]) threshold_q[t] <= wdata_i[$bits(prio_t)-1:0];
            end
        end
    end

    assign prio_o      = prio_q;
    assign enable_o    = enable_q;
    assign threshold_o = threshold_q;

endmodule

// File: plic/plic_target.sv
// PLIC target arbitration
// Finds the highest-priority pending and enabled source per target,
// lowest ID on a tie, gates it with the threshold and registers the
// external interrupt line

`timescale 1ns/1ps

module plic_target import periph_pkg::*; #(
    parameter int NumSources = periph_pkg::NumSources,
    parameter int NumTargets = periph_pkg::NumTargets
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  src_vec_t                  pending_i,
    input  prio_t    [NumSources-1:0] prio_i,
    input  src_vec_t [NumTargets-1:0] enable_i,
    input  prio_t    [NumTargets-1:0] threshold_i,
    output src_id_t  [NumTargets-1:0] max_id_o,
    output logic     [NumTargets-1:0] irq_o
);

    always_comb begin
        prio_t   best_prio;
        src_id_t best_id;
        for (int t = 0; t < NumTargets; t++) begin
            best_prio = '0;
            best_id   = '0;
            for (int i = 0; i < NumSources; i++) begin
                // Strict compare keeps the lower ID on a tie
                if (pending_i[i] && enable_i[t][i] && prio_i[i] > best_prio) begin
                    best_prio = prio_i[i];
                    best_id   = src_id_t'(i + 1);
                end
            end
            max_id_o[t] = (best_prio > threshold_i[t]) ? best_id : '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_o <= '0;
        end else begin
            for (int t = 0; t < NumTargets; t++) begin
                irq_o[t] <= (max_id_o[t] != '0);
            end
        end
    end

    for (genvar t = 0; t < NumTargets; t++) begin : gen_irq_chk
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            irq_o[t] |-> $past(max_id_o[t]) != '0);
    end

endmodule

// File: verilog/periph_top.sv
// Peripheral subsystem top level
// Register decoder, two timers and a two-target PLIC with level sources
// Sources 1..2 are the external lines, 3..4 the timer interrupts

`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
    parameter int NumSources = periph_pkg::NumSources,
    parameter int NumTargets = periph_pkg::NumTargets,
    parameter int TimerCnt   = periph_pkg::TimerCnt
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    input  logic                  req_write_i,
    input  reg_addr_t             req_addr_i,
    input  reg_data_t             req_wdata_i,
    output logic                  rsp_valid_o,
    output reg_data_t             rsp_rdata_o,
    output logic                  rsp_err_o,
    input  logic [1:0]            ext_irq_i,
    output logic [NumTargets-1:0] irq_o
);

    // Register bus towards the blocks
    logic        plic_sel;
    logic        timer_sel;
    logic [11:0] offset;
    logic        write;
    reg_data_t   wdata;
    reg_data_t   plic_rdata;
    logic        plic_err;
    reg_data_t   timer_rdata;
    logic        timer_err;

    // Interrupt path
    logic [TimerCnt-1:0]             timer_irq;
    src_vec_t                        pending;
    prio_t   [NumSources-1:0]        prio;
    src_vec_t [NumTargets-1:0]       enable;
    prio_t   [NumTargets-1:0]        threshold;
    src_id_t [NumTargets-1:0]        max_id;
    logic    [NumTargets-1:0]        claim;
    src_id_t [NumTargets-1:0]        claim_id;
    logic    [NumTargets-1:0]        complete;
    src_id_t [NumTargets-1:0]        complete_id;

    // ------------------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------------------
    reg_decode i_reg_decode (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_valid_i   ( req_valid_i ),
        .req_write_i   ( req_write_i ),
        .req_addr_i    ( req_addr_i  ),
        .req_wdata_i   ( req_wdata_i ),
        .plic_sel_o    ( plic_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .offset_o      ( offset      ),
        .write_o       ( write       ),
        .wdata_o       ( wdata       ),
        .plic_rdata_i  ( plic_rdata  ),
        .plic_err_i    ( plic_err    ),
        .timer_rdata_i ( timer_rdata ),
        .timer_err_i   ( timer_err   ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_rdata_o   ( rsp_rdata_o ),
        .rsp_err_o     ( rsp_err_o   )
    );

    timer_unit #(
        .TimerCnt ( TimerCnt )
    ) i_timer (
        .clk_i    ( clk_i       ),
        .rst_n_i  ( rst_n_i     ),
        .sel_i    ( timer_sel   ),
        .offset_i ( offset      ),
        .write_i  ( write       ),
        .wdata_i  ( wdata       ),
        .rdata_o  ( timer_rdata ),
        .err_o    ( timer_err   ),
        .irq_o    ( timer_irq   )
    );

    // ------------------------------------------------------------------------
    // PLIC
    // ------------------------------------------------------------------------
    plic_gateway #(
        .NumSources ( NumSources ),
        .NumTargets ( NumTargets )
    ) i_plic_gateway (
        .clk_i         ( clk_i                  ),
        .rst_n_i       ( rst_n_i                ),
        .src_i         ( {timer_irq, ext_irq_i} ),
        .claim_i       ( claim                  ),
        .claim_id_i    ( claim_id               ),
        .complete_i    ( complete               ),
        .complete_id_i ( complete_id            ),
        .pending_o     ( pending                )
    );

    plic_regs #(
        .NumSources ( NumSources ),
        .NumTargets ( NumTargets )
    ) i_plic_regs (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .sel_i         ( plic_sel    ),
        .offset_i      ( offset      ),
        .write_i       ( write       ),
        .wdata_i       ( wdata       ),
        .rdata_o       ( plic_rdata  ),
        .err_o         ( plic_err    ),
        .pending_i     ( pending     ),
        .max_id_i      ( max_id      ),
        .prio_o        ( prio        ),
        .enable_o      ( enable      ),
        .threshold_o   ( threshold   ),
        .claim_o       ( claim       ),
        .claim_id_o    ( claim_id    ),
        .complete_o    ( complete    ),
        .complete_id_o ( complete_id )
    );

    plic_target #(
        .NumSources ( NumSources ),
        .NumTargets ( NumTargets )
    ) i_plic_target (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .pending_i   ( pending   ),
        .prio_i      ( prio      ),
        .enable_i    ( enable    ),
        .threshold_i ( threshold ),
        .max_id_o    ( max_id    ),
        .irq_o       ( irq_o     )
    );

endmodule

// File: tb/tb_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock and an active-low reset released after a few cycles

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int Period    = 8,
    parameter int RstCycles = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(Period / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RstCycles) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: tb/periph_tb.sv
// Peripheral subsystem testbench
// Random register traffic and interrupt levels against a behavioral
// model of the PLIC registers, gateways and arbitration

`timescale 1ns/1ps

module periph_tb import periph_pkg::*; ();

    localparam int NumReq    = 400;  // Upper bound on bus requests
    localparam int ClkPeriod = 8;

    logic      clk, rst_n;
    logic      req_valid, req_write;
    reg_addr_t req_addr;
    reg_data_t req_wdata;
    logic [1:0] ext_irq;
    logic      rsp_valid, rsp_err;
    reg_data_t rsp_rdata;
    logic [NumTargets-1:0] irq;

    int errors   = 0;
    int checks   = 0;
    int n_tests  = 0;
    int n_req    = 0;
    logic chk_irq = 1'b0;

    // Model state
    prio_t    m_prio [NumSources] = '{default: '0};
    src_vec_t m_en [NumTargets] = '{default: '0};
    prio_t    m_thr [NumTargets] = '{default: '0};
    src_vec_t m_pend = '0;
    src_vec_t m_act = '0;
    logic [NumTargets-1:0] m_irq = '0;
    src_id_t  claim_exp [NumTargets] = '{default: '0};
    src_id_t  mid [NumTargets];
    src_vec_t chit, comp, new_pend;
    logic [11:0] off;

    tb_clk_gen #(.Period(ClkPeriod), .RstCycles(2)) i_clk_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    periph_top dut0 (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .req_valid_i ( req_valid ),
        .req_write_i ( req_write ),
        .req_addr_i  ( req_addr  ),
        .req_wdata_i ( req_wdata ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_rdata_o ( rsp_rdata ),
        .rsp_err_o   ( rsp_err   ),
        .ext_irq_i   ( ext_irq   ),
        .irq_o       ( irq       )
    );

    task automatic check(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("** Error at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    // Highest priority above threshold, lowest ID on a tie
    function automatic src_id_t arbitrate(input int t);
        for (int p = MaxPriority; p > m_thr[t]; p--) begin
            for (int s = 0; s < NumSources; s++) begin
                if (m_pend[s] && m_en[t][s] && m_prio[s] == p) return src_id_t'(s + 1);
            end
        end
        return '0;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model, stepped on every rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            for (int t = 0; t < NumTargets; t++) mid[t] = arbitrate(t);
            chit = '0;
            comp = '0;
            off  = req_addr[11:0];
            if (req_valid && req_addr[15:12] == RegionPlic) begin
                for (int t = 0; t < NumTargets; t++) begin
                    if (off == 12'h204 + 12'(8 * t)) begin
                        if (req_write && req_wdata[2:0] inside {[1:4]})
                            comp[req_wdata[2:0] - 1] = 1'b1;
                        if (!req_write) begin
                            claim_exp[t] = mid[t];
                            if (mid[t] != 0) chit[mid[t] - 1] = 1'b1;
                        end
                    end
                    if (req_write && off == 12'h100 + 12'(4 * t)) m_en[t] = req_wdata[3:0];
                    if (req_write && off == 12'h200 + 12'(8 * t)) m_thr[t] = req_wdata[2:0];
                end
                for (int s = 1; s <= NumSources; s++) begin
                    if (req_write && off == 12'(4 * s)) m_prio[s - 1] = req_wdata[2:0];
                end
            end
            new_pend = (m_pend & ~chit) | ({2'b00, ext_irq} & ~m_pend & ~m_act);
            m_act    = (m_act & ~comp) | (m_pend & chit);
            m_pend   = new_pend;
            for (int t = 0; t < NumTargets; t++) m_irq[t] = (mid[t] != 0);
        end
    end

    always @(negedge clk) begin
        if (rst_n && chk_irq) check(irq == m_irq, "irq_o differs from the model");
    end

    // One request, called 1 ns after a rising edge
    task automatic bus_access(input logic wr, input reg_addr_t addr, input reg_data_t wd,
                              output reg_data_t rd, output logic er);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wd;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        n_req++;
        check(rsp_valid == 1'b1, "no response in the cycle after the request");
        rd = rsp_rdata;
        er = rsp_err;
    endtask

    task automatic wr_reg(input reg_addr_t addr, input reg_data_t wd);
        reg_data_t rd;
        logic      er;
        bus_access(1'b1, addr, wd, rd, er);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            check(rsp_valid == 1'b0, "response without a request");
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        n_tests++;
        $display("test %s: done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        reg_data_t rd, wd, mask;
        reg_addr_t addr;
        logic      er;
        int        e0, k, t, c, waited;
        void'($urandom(31));
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        ext_irq   = 2'b00;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        check(rsp_valid == 0 && rsp_err == 0 && irq == 0, "outputs not 0 after reset");
        chk_irq = 1'b1;

        // ---------------------------------------------------------------
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            k  = $urandom % 10;
            wd = $urandom;
            if (k < 4) begin
                addr = 16'(4 * (k + 1));
                mask = 32'h7;
            end else if (k < 6) begin
                addr = 16'h100 + 16'(4 * (k - 4));
                mask = 32'hF;
            end else if (k < 8) begin
                addr = 16'h200 + 16'(8 * (k - 6));
                mask = 32'h7;
            end else begin
                addr = 16'h1004 + 16'(16 * (k - 8));
                mask = 32'hFFFF_FFFF;
            end
            wr_reg(addr, wd);
            bus_access(1'b0, addr, '0, rd, er);
            check(!er && rd == (wd & mask), $sformatf("readback of 0x%04h gave 0x%08h", addr, rd));
            idle(1);
        end
        end_test("readback", e0);

        // ---------------------------------------------------------------
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            case (i)
                0: addr = 16'h2000 | 16'($urandom % 4096);
                1: addr = 16'hF000 | 16'($urandom % 4096);
                2: addr = 16'h0000;
                3: addr = 16'h0084;
                4: addr = 16'h1020;
                default: addr = 16'h0300;
            endcase
            bus_access(i[0], addr, $urandom, rd, er);
            check(er && rd == 0, $sformatf("access to 0x%04h did not return an error", addr));
        end
        idle(1);
        end_test("errors", e0);

        // ---------------------------------------------------------------
        e0 = errors;
        for (int i = 0; i < 30; i++) begin
            wr_reg(16'h0004, $urandom);
            wr_reg(16'h0008, (i % 4 == 0) ? 32'(m_prio[0]) : $urandom);
            wr_reg(16'h0100, $urandom);
            wr_reg(16'h0104, $urandom);
            wr_reg(16'h0200 + 16'(8 * ($urandom % 2)), $urandom % 4);
            ext_irq = 2'($urandom);
            idle(3);
            t = $urandom % 2;
            bus_access(1'b0, 16'h204 + 16'(8 * t), '0, rd, er);
            check(rd == 32'(claim_exp[t]), $sformatf("claim gave %0d, model %0d", rd,
                  claim_exp[t]));
            if (rd != 0) wr_reg(16'h204 + 16'(8 * t), rd);
            idle(1);
        end
        ext_irq = 2'b00;
        idle(2);
        end_test("arbitration", e0);

        // ---------------------------------------------------------------
        e0 = errors;
        wr_reg(16'h0004, 32'd5);
        wr_reg(16'h0008, 32'd0);
        wr_reg(16'h0100, 32'h1);
        wr_reg(16'h0200, 32'd0);
        ext_irq = 2'b01;
        idle(3);
        bus_access(1'b0, 16'h0204, '0, rd, er);
        check(rd == 1, "claim of source 1 failed");
        idle(3);
        bus_access(1'b0, 16'h0080, '0, rd, er);
        check(rd[0] == 1'b0, "claimed source pending again before complete");
        wr_reg(16'h0204, 32'd1);
        idle(3);
        bus_access(1'b0, 16'h0080, '0, rd, er);
        check(rd[0] == 1'b1, "source not pending again after complete");
        ext_irq = 2'b00;
        bus_access(1'b0, 16'h0204, '0, rd, er);
        if (rd != 0) wr_reg(16'h0204, rd);
        idle(2);
        end_test("claim_complete", e0);

        // ---------------------------------------------------------------
        e0 = errors;
        wr_reg(16'h0004, 32'd0);
        wr_reg(16'h0008, 32'd2);
        wr_reg(16'h0100, 32'hF);
        wr_reg(16'h0104, 32'hF);
        wr_reg(16'h0200, 32'd3);
        wr_reg(16'h0208, 32'd2);
        ext_irq = 2'b10;
        idle(4);
        check(irq == 0, "irq_o raised at or below threshold");
        for (int tt = 0; tt < NumTargets; tt++) begin
            bus_access(1'b0, 16'h204 + 16'(8 * tt), '0, rd, er);
            check(rd == 0, "claim returned a source gated by the threshold");
        end
        ext_irq = 2'b00;
        idle(2);
        end_test("threshold", e0);

        // ---------------------------------------------------------------
        e0 = errors;
        chk_irq = 1'b0;
        wr_reg(16'h0008, 32'd0);
        wr_reg(16'h000C, 32'd4);
        wr_reg(16'h0010, 32'd0);
        wr_reg(16'h0100, 32'h4);
        wr_reg(16'h0104, 32'h0);
        wr_reg(16'h0200, 32'd0);
        c = 5 + $urandom % 16;
        wr_reg(16'h1004, c);
        wr_reg(16'h1000, 32'd0);
        wr_reg(16'h1008, 32'd1);
        waited = 0;
        do begin
            bus_access(1'b0, 16'h100C, '0, rd, er);
            waited++;
        end while (rd[0] == 1'b0 && waited <= c + 4);
        check(rd[0] == 1'b1, $sformatf("timer flag not set within %0d cycles", c + 4));
        waited = 0;
        while (irq[0] == 1'b0 && waited < 10) begin
            idle(1);
            waited++;
        end
        check(irq[0] == 1'b1, "timer interrupt did not reach irq_o");
        wr_reg(16'h1008, 32'd0);
        wr_reg(16'h100C, 32'd1);
        bus_access(1'b0, 16'h100C, '0, rd, er);
        check(rd[0] == 1'b0, "timer flag not cleared");
        bus_access(1'b0, 16'h0204, '0, rd, er);
        check(rd == 3, "claim did not return the timer source");
        wr_reg(16'h0204, 32'd3);
        idle(3);
        check(irq[0] == 1'b0, "irq_o still high after clear and complete");
        end_test("timer", e0);

        $display("%0d tests, %0d checks, %0d errors, %0d requests", n_tests, checks,
                 errors, n_req);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(NumReq * 20 * ClkPeriod + 1000);
        $display("Timeout: the tests did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: periph.f
common/periph_pkg.sv
verilog/reg_decode.sv
timer/timer_unit.sv
plic/plic_gateway.sv
plic/plic_regs.sv
plic/plic_target.sv
verilog/periph_top.sv
tb/tb_clk_gen.sv
tb/periph_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= periph_tb
FLIST     ?= periph.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
